/* logic/sd_pkg.sv */
package sd_pkg;

   // token widths
   localparam int TOKEN_W = 48;
   localparam int RESP_W  = 136;

   typedef logic [5:0] cmd_idx_t;
   typedef logic [3:0] card_state_t;
   typedef logic [3:0] resp_type_t;

   localparam cmd_idx_t CMD0_GO_IDLE        = 6'd0;
   localparam cmd_idx_t CMD2_ALL_SEND_CID   = 6'd2;
   localparam cmd_idx_t CMD3_SEND_REL_ADDR  = 6'd3;
   localparam cmd_idx_t CMD7_SEL_CARD       = 6'd7;
   localparam cmd_idx_t CMD8_SEND_IF_COND   = 6'd8;
   localparam cmd_idx_t CMD9_SEND_CSD       = 6'd9;
   localparam cmd_idx_t CMD10_SEND_CID      = 6'd10;
   localparam cmd_idx_t CMD13_SEND_STATUS   = 6'd13;
   localparam cmd_idx_t CMD15_GO_INACTIVE   = 6'd15;
   localparam cmd_idx_t CMD55_APP_CMD       = 6'd55;
   localparam cmd_idx_t ACMD6_SET_BUS_WIDTH = 6'd6;
   localparam cmd_idx_t ACMD41_SEND_OP_COND = 6'd41;

   localparam card_state_t CARD_IDLE  = 4'd0;
   localparam card_state_t CARD_READY = 4'd1;
   localparam card_state_t CARD_IDENT = 4'd2;
   localparam card_state_t CARD_STBY  = 4'd3;
   localparam card_state_t CARD_TRAN  = 4'd4;
   localparam card_state_t CARD_INA   = 4'd15;

   localparam resp_type_t RESP_NONE = 4'd0;
   localparam resp_type_t RESP_R1   = 4'd1;
   localparam resp_type_t RESP_R1B  = 4'd2;
   localparam resp_type_t RESP_R2   = 4'd3;
   localparam resp_type_t RESP_R3   = 4'd4;
   localparam resp_type_t RESP_R6   = 4'd5;
   localparam resp_type_t RESP_R7   = 4'd6;
   localparam resp_type_t RESP_BAD  = 4'd15;

   // card status bits, current state sits in 12:9
   localparam int STAT_COM_CRC_ERROR   = 23;
   localparam int STAT_ILLEGAL_COMMAND = 22;
   localparam int STAT_READY_FOR_DATA  = 8;
   localparam int STAT_APP_CMD         = 5;

   localparam logic [15:0] RCA_STEP           = 16'h1337;
   localparam logic [23:0] OCR_VOLTAGE_WINDOW = 24'hFF8000;
   // high capacity, not yet powered up
   localparam logic [31:0] OCR_RESET          = {8'h40, OCR_VOLTAGE_WINDOW};
   localparam int          OCR_POWERED_UP     = 31;
   localparam int          ACMD41_READY_COUNT = 3;

   // command sequencer steps
   localparam logic [1:0] EXEC_IDLE   = 2'd0;
   localparam logic [1:0] EXEC_EVAL   = 2'd1;
   localparam logic [1:0] EXEC_STATUS = 2'd2;
   localparam logic [1:0] EXEC_WAIT   = 2'd3;

   localparam logic [7:0]  CID_MID = 8'h02;
   localparam logic [15:0] CID_OID = 16'h544D;
   localparam logic [39:0] CID_PNM = 40'h5344313647;
   localparam logic [7:0]  CID_PRV = 8'h10;
   localparam logic [31:0] CID_PSN = 32'h1A2B3C4D;
   localparam logic [11:0] CID_MDT = 12'h0E5;
   localparam logic [127:0] CID_VALUE = {CID_MID, CID_OID, CID_PNM, CID_PRV, CID_PSN,
                                         4'h0, CID_MDT, 8'hFF};

   // csd version 2.0, 512 byte blocks
   localparam logic [1:0]  CSD_STRUCTURE   = 2'b01;
   localparam logic [7:0]  CSD_TAAC        = 8'h0E;
   localparam logic [7:0]  CSD_NSAC        = 8'h00;
   localparam logic [7:0]  CSD_TRAN_SPEED  = 8'h32;
   localparam logic [11:0] CSD_CCC         = 12'h5B5;
   localparam logic [3:0]  CSD_BL_LEN      = 4'h9;
   localparam logic [21:0] CSD_C_SIZE      = 22'h003B37;
   localparam logic [6:0]  CSD_SECTOR_SIZE = 7'h7F;
   localparam logic [2:0]  CSD_R2W_FACTOR  = 3'b010;
   localparam logic [127:0] CSD_VALUE = {CSD_STRUCTURE, 6'h0, CSD_TAAC, CSD_NSAC, CSD_TRAN_SPEED,
                                         CSD_CCC, CSD_BL_LEN, 4'h0, 6'h0, CSD_C_SIZE, 1'b0,
                                         1'b1, CSD_SECTOR_SIZE, 7'h00, 1'b0, 2'b00,
                                         CSD_R2W_FACTOR, CSD_BL_LEN, 1'b0, 5'h0, 8'h00, 8'hFF};

   // one argument word, read per command
   typedef union packed {
      struct packed {
         logic [15:0] rca;
         logic [15:0] stuff;
      } rca_view;
      struct packed {
         logic [19:0] reserved;
         logic [3:0]  voltage;
         logic [7:0]  check;
      } if_cond_view;
      struct packed {
         logic        busy;
         logic        hcs;
         logic [5:0]  reserved;
         logic [23:0] window;
      } op_cond_view;
   } cmd_arg_u;

endpackage

/* logic/edge_sync.sv */
module edge_sync #(
   parameter int width = 1
) (
   input  logic             clk_50,
   input  logic [width-1:0] async_in,
   output logic [width-1:0] sync_out,
   output logic [width-1:0] rise
);

   logic [width-1:0] stage_1;
   logic [width-1:0] stage_2;
   logic [width-1:0] stage_3;

   always_ff @(posedge clk_50) begin
      stage_1 <= async_in;
      stage_2 <= stage_1;
      stage_3 <= stage_2;
   end

   assign sync_out = stage_3;
   // edge seen between the last two stages
   assign rise = stage_2 & ~stage_3;

   // a pulse lasts one cycle
   assert property (@(posedge clk_50) (rise & $past(rise)) == '0);

endmodule

/* logic/cmd_decode.sv */
module cmd_decode (
   input  logic                       clk_50,
   input  logic                       reset_s,
   input  logic [sd_pkg::TOKEN_W-1:0] cmd_in_s,
   input  logic                       crc_good_s,
   input  logic                       cmd_act_rise,
   input  logic                       busy,
   output logic                       cmd_valid,
   output sd_pkg::cmd_idx_t           cmd_index,
   output sd_pkg::cmd_arg_u           cmd_arg,
   output logic                       crc_error
);

   import sd_pkg::*;

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         cmd_valid <= 1'b0;
         crc_error <= 1'b0;
      end else begin
         cmd_valid <= 1'b0;
         crc_error <= 1'b0;
         // edges while a command is in flight are dropped
         if (cmd_act_rise && !busy) begin
            if (crc_good_s) begin
               cmd_valid <= 1'b1;
            end else begin
               crc_error <= 1'b1;
            end
         end
      end
   end

   // index and argument sit below the start and direction bits
   always_ff @(posedge clk_50) begin
      if (cmd_act_rise && !busy && crc_good_s) begin
         cmd_index <= cmd_in_s[TOKEN_W-3 -: 6];
         cmd_arg   <= cmd_in_s[TOKEN_W-9 -: 32];
      end
   end

   // one outcome per token
   assert property (@(posedge clk_50) disable iff (!reset_s)
      !(cmd_valid && crc_error));

endmodule

/* logic/card_execute.sv */
module card_execute (
   input  logic                clk_50,
   input  logic                reset_s,
   input  logic                cmd_valid,
   input  sd_pkg::cmd_idx_t    cmd_index,
   input  sd_pkg::cmd_arg_u    cmd_arg,
   input  logic                crc_error,
   input  logic                resp_finished,
   output logic                busy,
   output logic                resp_start,
   output sd_pkg::resp_type_t  resp_type,
   output logic [31:0]         card_status,
   output logic [15:0]         card_rca,
   output logic [31:0]         card_ocr,
   output sd_pkg::cmd_arg_u    echo_arg,
   output sd_pkg::card_state_t card_state,
   output logic                err_cmd_crc,
   output logic                err_unhandled_cmd,
   output logic                info_card_desel
);

   import sd_pkg::*;

   logic [1:0]  exec_state;
   card_state_t state_next;
   logic [3:0]  acmd41_count;
   logic        app_cmd;
   logic        rca_match;
   logic        in_stby_tran;

   assign busy         = exec_state != EXEC_IDLE;
   assign rca_match    = cmd_arg.rca_view.rca == card_rca;
   assign in_stby_tran = card_state == CARD_STBY || card_state == CARD_TRAN;

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         exec_state        <= EXEC_IDLE;
         resp_start        <= 1'b0;
         resp_type         <= RESP_NONE;
         card_status       <= '0;
         card_status[STAT_READY_FOR_DATA] <= 1'b1;
         card_rca          <= '0;
         card_ocr          <= OCR_RESET;
         card_state        <= CARD_IDLE;
         state_next        <= CARD_IDLE;
         acmd41_count      <= '0;
         app_cmd           <= 1'b0;
         err_cmd_crc       <= 1'b0;
         err_unhandled_cmd <= 1'b0;
         info_card_desel   <= 1'b0;
      end else begin
         resp_start <= 1'b0;
         case (exec_state)
            EXEC_IDLE: begin
               if (crc_error) begin
                  card_status[STAT_COM_CRC_ERROR] <= 1'b1;
                  err_cmd_crc <= 1'b1;
               end
               if (cmd_valid) begin
                  exec_state <= EXEC_EVAL;
               end
            end
            EXEC_EVAL: begin
               exec_state <= EXEC_STATUS;
               state_next <= card_state;
               // anything not matched below is illegal here
               resp_type  <= RESP_BAD;
               if (app_cmd) begin
                  case (cmd_index)
                     ACMD6_SET_BUS_WIDTH: begin
                        if (card_state == CARD_TRAN) resp_type <= RESP_R1;
                     end
                     ACMD41_SEND_OP_COND: begin
                        if (card_state == CARD_IDLE) begin
                           resp_type <= RESP_R3;
                           if (acmd41_count < ACMD41_READY_COUNT) begin
                              acmd41_count <= acmd41_count + 1'b1;
                           end
                           // zero window is a query only
                           if (cmd_arg.op_cond_view.window != '0 && cmd_arg.op_cond_view.hcs &&
                               acmd41_count >= ACMD41_READY_COUNT) begin
                              card_ocr[OCR_POWERED_UP] <= 1'b1;
                              state_next <= CARD_READY;
                           end
                        end
                     end
                     default: begin
                        // retry as a plain command next cycle
                        app_cmd    <= 1'b0;
                        exec_state <= EXEC_EVAL;
                     end
                  endcase
               end else begin
                  case (cmd_index)
                     CMD0_GO_IDLE: begin
                        if (card_state != CARD_INA) begin
                           resp_type    <= RESP_NONE;
                           state_next   <= CARD_IDLE;
                           card_rca     <= '0;
                           card_ocr     <= OCR_RESET;
                           acmd41_count <= '0;
                           app_cmd      <= 1'b0;
                        end
                     end
                     CMD2_ALL_SEND_CID: begin
                        if (card_state == CARD_READY) begin
                           resp_type  <= RESP_R2;
                           state_next <= CARD_IDENT;
                        end
                     end
                     CMD3_SEND_REL_ADDR: begin
                        if (card_state == CARD_IDENT || card_state == CARD_STBY) begin
                           card_rca   <= card_rca + RCA_STEP;
                           resp_type  <= RESP_R6;
                           state_next <= CARD_STBY;
                        end
                     end
                     CMD7_SEL_CARD: begin
                        if (rca_match) begin
                           if (card_state == CARD_STBY) begin
                              resp_type  <= RESP_R1B;
                              state_next <= CARD_TRAN;
                           end
                        end else begin
                           if (in_stby_tran) state_next <= CARD_STBY;
                           info_card_desel <= 1'b1;
                           resp_type       <= RESP_NONE;
                        end
                     end
                     CMD8_SEND_IF_COND: begin
                        if (card_state == CARD_IDLE) begin
                           resp_type <= RESP_NONE;
                           if (cmd_arg.if_cond_view.voltage == 4'd1) begin
                              resp_type <= RESP_R7;
                              echo_arg.if_cond_view.reserved <= '0;
                              echo_arg.if_cond_view.voltage  <= cmd_arg.if_cond_view.voltage;
                              echo_arg.if_cond_view.check    <= cmd_arg.if_cond_view.check;
                           end
                        end
                     end
                     CMD9_SEND_CSD, CMD10_SEND_CID: begin
                        if (!rca_match) resp_type <= RESP_NONE;
                        else if (card_state == CARD_STBY) resp_type <= RESP_R2;
                     end
                     CMD13_SEND_STATUS: begin
                        if (!rca_match) resp_type <= RESP_NONE;
                        else if (in_stby_tran) resp_type <= RESP_R1;
                     end
                     CMD15_GO_INACTIVE: begin
                        if (!rca_match) begin
                           resp_type <= RESP_NONE;
                        end else if (in_stby_tran) begin
                           resp_type  <= RESP_NONE;
                           state_next <= CARD_INA;
                        end
                     end
                     CMD55_APP_CMD: begin
                        if (card_state == CARD_IDLE || rca_match) begin
                           if (card_state == CARD_IDLE || in_stby_tran) begin
                              resp_type <= RESP_R1;
                              app_cmd   <= 1'b1;
                              card_status[STAT_APP_CMD] <= 1'b1;
                           end
                        end else begin
                           resp_type <= RESP_NONE;
                        end
                     end
                     default: begin
                        // cmd1 and cmd5 are probes from other card types
                        err_unhandled_cmd <= err_unhandled_cmd |
                                             (cmd_index != 6'd1 && cmd_index != 6'd5);
                     end
                  endcase
               end
            end
            EXEC_STATUS: begin
               card_status[12:9] <= card_state;
               if (resp_type == RESP_NONE) begin
                  card_status[STAT_COM_CRC_ERROR]   <= 1'b0;
                  card_status[STAT_ILLEGAL_COMMAND] <= 1'b0;
                  card_state <= state_next;
                  exec_state <= EXEC_IDLE;
               end else if (resp_type == RESP_BAD) begin
                  // no answer, the bit is reported later
                  card_status[STAT_COM_CRC_ERROR]   <= 1'b0;
                  card_status[STAT_ILLEGAL_COMMAND] <= 1'b1;
                  exec_state <= EXEC_IDLE;
               end else begin
                  resp_start <= 1'b1;
                  exec_state <= EXEC_WAIT;
               end
            end
            default: begin
               if (resp_finished) begin
                  card_status[STAT_COM_CRC_ERROR]   <= 1'b0;
                  card_status[STAT_ILLEGAL_COMMAND] <= 1'b0;
                  if (app_cmd && cmd_index != CMD55_APP_CMD) begin
                     app_cmd <= 1'b0;
                     card_status[STAT_APP_CMD] <= 1'b0;
                  end
                  // clear on read
                  if (cmd_index == CMD13_SEND_STATUS) card_status[STAT_APP_CMD] <= 1'b0;
                  card_state <= state_next;
                  exec_state <= EXEC_IDLE;
               end
            end
         endcase
      end
   end

   // only real tokens reach the formatter
   assert property (@(posedge clk_50) disable iff (!reset_s)
      resp_start |-> (resp_type != RESP_NONE && resp_type != RESP_BAD));

endmodule

/* logic/resp_format.sv */
module resp_format (
   input  logic                      clk_50,
   input  logic                      reset_s,
   input  logic                      resp_start,
   input  sd_pkg::resp_type_t        resp_type,
   input  sd_pkg::cmd_idx_t          cmd_index,
   input  logic [31:0]               card_status,
   input  logic [15:0]               card_rca,
   input  logic [31:0]               card_ocr,
   input  sd_pkg::cmd_arg_u          echo_arg,
   input  logic                      resp_done_rise,
   output logic [sd_pkg::RESP_W-1:0] resp_out,
   output sd_pkg::resp_type_t        resp_type_out,
   output logic                      resp_act,
   output logic                      resp_finished
);

   import sd_pkg::*;

   logic [RESP_W-1:0] token;
   logic [127:0]      long_reg;

   assign long_reg = (cmd_index == CMD9_SEND_CSD) ? CSD_VALUE : CID_VALUE;

   always_comb begin
      case (resp_type)
         RESP_R2: token = {2'b00, 6'b111111, long_reg[127:1], 1'b1};
         RESP_R3: token = {2'b00, 6'b111111, card_ocr, 8'hFF, 88'h0};
         RESP_R6: begin
            token = {2'b00, CMD3_SEND_REL_ADDR, card_rca, card_status[23:22],
                     card_status[19], card_status[12:0], 8'h01, 88'h0};
         end
         RESP_R7: token = {2'b00, CMD8_SEND_IF_COND, echo_arg, 8'h01, 88'h0};
         // r1 and r1b share one layout
         default: token = {2'b00, cmd_index, card_status, 8'h01, 88'h0};
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         resp_type_out <= RESP_NONE;
         resp_act      <= 1'b0;
         resp_finished <= 1'b0;
      end else begin
         resp_finished <= 1'b0;
         if (resp_start) begin
            resp_type_out <= resp_type;
            resp_act      <= 1'b1;
         end else if (resp_act && resp_done_rise) begin
            // phy has shifted the token out
            resp_act      <= 1'b0;
            resp_finished <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_50) begin
      if (resp_start) begin
         resp_out <= token;
      end
   end

   // token held for the whole strobe
   assert property (@(posedge clk_50) disable iff (!reset_s)
      resp_act |=> (!resp_act || $stable(resp_out)));

endmodule

/* logic/sd_cmd_link.sv */
module sd_cmd_link (
   input  logic                       clk_50,
   input  logic                       reset_s,
   input  logic [sd_pkg::TOKEN_W-1:0] phy_cmd_in,
   input  logic                       phy_cmd_in_crc_good,
   input  logic                       phy_cmd_in_act,
   input  logic                       phy_resp_done,
   output logic [sd_pkg::RESP_W-1:0]  phy_resp_out,
   output sd_pkg::resp_type_t         phy_resp_type,
   output logic                       phy_resp_act,
   output sd_pkg::card_state_t        link_card_state,
   output logic                       err_cmd_crc,
   output logic                       err_unhandled_cmd,
   output logic                       info_card_desel
);

   import sd_pkg::*;

   logic [TOKEN_W-1:0] cmd_in_s;
   logic               crc_good_s;
   logic               cmd_act_rise;
   logic               resp_done_rise;
   logic               cmd_valid;
   cmd_idx_t           cmd_index;
   cmd_arg_u           cmd_arg;
   logic               crc_error;
   logic               busy;
   logic               resp_start;
   resp_type_t         resp_type;
   logic [31:0]        card_status;
   logic [15:0]        card_rca;
   logic [31:0]        card_ocr;
   cmd_arg_u           echo_arg;
   logic               resp_finished;

   // phy signals cross from the sd clock domain
   edge_sync #(.width(TOKEN_W)) i_sync_cmd (.clk_50(clk_50), .async_in(phy_cmd_in),
      .sync_out(cmd_in_s), .rise());
   edge_sync i_sync_crc (.clk_50(clk_50), .async_in(phy_cmd_in_crc_good),
      .sync_out(crc_good_s), .rise());
   edge_sync i_sync_act (.clk_50(clk_50), .async_in(phy_cmd_in_act),
      .sync_out(), .rise(cmd_act_rise));
   edge_sync i_sync_done (.clk_50(clk_50), .async_in(phy_resp_done),
      .sync_out(), .rise(resp_done_rise));

   cmd_decode i_cmd_decode (.clk_50(clk_50), .reset_s(reset_s), .cmd_in_s(cmd_in_s),
      .crc_good_s(crc_good_s), .cmd_act_rise(cmd_act_rise), .busy(busy),
      .cmd_valid(cmd_valid), .cmd_index(cmd_index), .cmd_arg(cmd_arg), .crc_error(crc_error));

   card_execute i_card_execute (.clk_50(clk_50), .reset_s(reset_s), .cmd_valid(cmd_valid),
      .cmd_index(cmd_index), .cmd_arg(cmd_arg), .crc_error(crc_error),
      .resp_finished(resp_finished), .busy(busy), .resp_start(resp_start),
      .resp_type(resp_type), .card_status(card_status), .card_rca(card_rca),
      .card_ocr(card_ocr), .echo_arg(echo_arg), .card_state(link_card_state),
      .err_cmd_crc(err_cmd_crc), .err_unhandled_cmd(err_unhandled_cmd),
      .info_card_desel(info_card_desel));

   resp_format i_resp_format (.clk_50(clk_50), .reset_s(reset_s), .resp_start(resp_start),
      .resp_type(resp_type), .cmd_index(cmd_index), .card_status(card_status),
      .card_rca(card_rca), .card_ocr(card_ocr), .echo_arg(echo_arg),
      .resp_done_rise(resp_done_rise), .resp_out(phy_resp_out),
      .resp_type_out(phy_resp_type), .resp_act(phy_resp_act),
      .resp_finished(resp_finished));

endmodule

/* tests/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: index, argument, crc good, response type, response token, card state,
// sticky flags {desel, unhandled, crc}, hold done low during the response
task automatic load_rows();
   add_row(6'd0, 32'h0, 1, RESP_NONE, '0, CARD_IDLE, 3'b000, 0);
   add_row(6'd8, 32'h0000_01AA, 1, RESP_R7, echo_token(32'h1AA), CARD_IDLE, 3'b000, 0);
   // three early ACMD41 rounds leave the card idle
   add_row(6'd55, 32'h0, 1, RESP_R1, short_token(6'd55, 32'h120), CARD_IDLE, 3'b000, 0);
   add_row(6'd41, OP_ARG, 1, RESP_R3, ocr_token(32'h40FF_8000), CARD_IDLE, 3'b000, 0);
   add_row(6'd55, 32'h0, 1, RESP_R1, short_token(6'd55, 32'h120), CARD_IDLE, 3'b000, 0);
   add_row(6'd41, OP_ARG, 1, RESP_R3, ocr_token(32'h40FF_8000), CARD_IDLE, 3'b000, 0);
   add_row(6'd55, 32'h0, 1, RESP_R1, short_token(6'd55, 32'h120), CARD_IDLE, 3'b000, 0);
   add_row(6'd41, OP_ARG, 1, RESP_R3, ocr_token(32'h40FF_8000), CARD_IDLE, 3'b000, 0);
   add_row(6'd55, 32'h0, 1, RESP_R1, short_token(6'd55, 32'h120), CARD_IDLE, 3'b000, 0);
   add_row(6'd41, OP_ARG, 1, RESP_R3, ocr_token(32'hC0FF_8000), CARD_READY, 3'b000, 0);
   add_row(6'd2, 32'h0, 1, RESP_R2, long_token(CID_VALUE), CARD_IDENT, 3'b000, 0);
   add_row(6'd3, 32'h0, 1, RESP_R6, rca_token(16'h1337, 32'h500), CARD_STBY, 3'b000, 0);
   // addressed commands
   add_row(6'd9, RCA_ARG, 1, RESP_R2, long_token(CSD_VALUE), CARD_STBY, 3'b000, 0);
   add_row(6'd10, RCA_ARG, 1, RESP_R2, long_token(CID_VALUE), CARD_STBY, 3'b000, 0);
   add_row(6'd7, RCA_ARG, 1, RESP_R1B, short_token(6'd7, 32'h700), CARD_TRAN, 3'b000, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h900), CARD_TRAN, 3'b000, 0);
   add_row(6'd7, 32'h1234_0000, 1, RESP_NONE, '0, CARD_STBY, 3'b100, 0);
   // crc error, then clear on the next good command
   add_row(6'd13, RCA_ARG, 0, RESP_NONE, '0, CARD_STBY, 3'b101, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h80_0700), CARD_STBY, 3'b101, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h700), CARD_STBY, 3'b101, 0);
   // illegal and unknown commands
   add_row(6'd2, 32'h0, 1, RESP_NONE, '0, CARD_STBY, 3'b101, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h40_0700), CARD_STBY, 3'b101, 0);
   add_row(6'd20, 32'h0, 1, RESP_NONE, '0, CARD_STBY, 3'b111, 0);
   add_row(6'd7, RCA_ARG, 1, RESP_R1B, short_token(6'd7, 32'h40_0700), CARD_TRAN, 3'b111, 0);
   // application commands
   add_row(6'd55, RCA_ARG, 1, RESP_R1, short_token(6'd55, 32'h920), CARD_TRAN, 3'b111, 0);
   add_row(6'd6, 32'h2, 1, RESP_R1, short_token(6'd6, 32'h920), CARD_TRAN, 3'b111, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h900), CARD_TRAN, 3'b111, 0);
   add_row(6'd55, RCA_ARG, 1, RESP_R1, short_token(6'd55, 32'h920), CARD_TRAN, 3'b111, 0);
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h920), CARD_TRAN, 3'b111, 0);
   // back-pressure, then inactive
   add_row(6'd13, RCA_ARG, 1, RESP_R1, short_token(6'd13, 32'h900), CARD_TRAN, 3'b111, 1);
   add_row(6'd15, RCA_ARG, 1, RESP_NONE, '0, CARD_INA, 3'b111, 0);
   add_row(6'd0, 32'h0, 1, RESP_NONE, '0, CARD_INA, 3'b111, 0);
endtask

`endif

/* tests/tb_sd_cmd_link.sv */
module tb_sd_cmd_link;

   timeunit 1ns;
   timeprecision 100ps;

   import sd_pkg::*;

   localparam int          RAND_COUNT = 8;
   localparam logic [31:0] RCA_ARG    = 32'h1337_0000;
   // hcs set, full voltage window
   localparam logic [31:0] OP_ARG     = 32'h40FF_8000;

   typedef struct packed {
      cmd_idx_t          idx;
      logic [31:0]       arg;
      logic              crc;
      resp_type_t        typ;
      logic [RESP_W-1:0] tok;
      card_state_t       st;
      logic [2:0]        flags;
      logic              hold;
   } vec_t;

   logic                clk_50;
   logic                reset_s;
   logic [TOKEN_W-1:0]  phy_cmd_in;
   logic                phy_cmd_in_crc_good;
   logic                phy_cmd_in_act;
   logic                phy_resp_done;
   logic [RESP_W-1:0]   phy_resp_out;
   resp_type_t          phy_resp_type;
   logic                phy_resp_act;
   card_state_t         link_card_state;
   logic                err_cmd_crc;
   logic                err_unhandled_cmd;
   logic                info_card_desel;

   vec_t rows[$];
   logic rows_loaded = 1'b0;
   int   errors = 0;
   int   checks = 0;

   sd_cmd_link i_sd_cmd_link (.clk_50(clk_50), .reset_s(reset_s), .phy_cmd_in(phy_cmd_in),
      .phy_cmd_in_crc_good(phy_cmd_in_crc_good), .phy_cmd_in_act(phy_cmd_in_act),
      .phy_resp_done(phy_resp_done), .phy_resp_out(phy_resp_out),
      .phy_resp_type(phy_resp_type), .phy_resp_act(phy_resp_act),
      .link_card_state(link_card_state), .err_cmd_crc(err_cmd_crc),
      .err_unhandled_cmd(err_unhandled_cmd), .info_card_desel(info_card_desel));

   function automatic logic [RESP_W-1:0] short_token(input cmd_idx_t idx,
                                                     input logic [31:0] status);
      return {2'b00, idx, status, 8'h01, 88'h0};
   endfunction

   function automatic logic [RESP_W-1:0] long_token(input logic [127:0] value);
      return {2'b00, 6'b111111, value[127:1], 1'b1};
   endfunction

   function automatic logic [RESP_W-1:0] ocr_token(input logic [31:0] ocr);
      return {2'b00, 6'b111111, ocr, 8'hFF, 88'h0};
   endfunction

   function automatic logic [RESP_W-1:0] rca_token(input logic [15:0] rca,
                                                   input logic [31:0] status);
      return {2'b00, 6'd3, rca, status[23:22], status[19], status[12:0], 8'h01, 88'h0};
   endfunction

   function automatic logic [RESP_W-1:0] echo_token(input logic [31:0] arg);
      return {2'b00, 6'd8, 20'h0, arg[11:0], 8'h01, 88'h0};
   endfunction

   task automatic add_row(input cmd_idx_t idx, input logic [31:0] arg, input logic crc,
                          input resp_type_t typ, input logic [RESP_W-1:0] tok,
                          input card_state_t st, input logic [2:0] flags, input logic hold);
      rows.push_back({idx, arg, crc, typ, tok, st, flags, hold});
   endtask

   `include "tb_vectors.svh"

   // token first, act two cycles later so the synchronized token is settled
   task automatic send_cmd(input cmd_idx_t idx, input logic [31:0] arg, input logic crc);
      phy_cmd_in          = {2'b01, idx, arg, 7'h00, 1'b1};
      phy_cmd_in_crc_good = crc;
      repeat (2) @(negedge clk_50);
      phy_cmd_in_act = 1'b1;
      repeat (6) @(negedge clk_50);
      phy_cmd_in_act = 1'b0;
   endtask

   task automatic wait_resp(output logic seen);
      seen = 1'b0;
      for (int i = 0; i < 40 && !seen; i++) begin
         if (phy_resp_act) seen = 1'b1;
         else @(negedge clk_50);
      end
   endtask

   task automatic expect_quiet(input int row);
      for (int i = 0; i < 40; i++) begin
         @(negedge clk_50);
         if (phy_resp_act) begin
            $display("row %0d: a response was sent where none was expected", row);
            errors++;
            break;
         end
      end
   endtask

   task automatic release_resp(input int row);
      logic gone;
      gone = 1'b0;
      phy_resp_done = 1'b1;
      for (int i = 0; i < 40 && !gone; i++) begin
         @(negedge clk_50);
         if (!phy_resp_act) gone = 1'b1;
      end
      if (!gone) begin
         $display("row %0d: resp_act did not fall after done", row);
         errors++;
      end
      phy_resp_done = 1'b0;
      repeat (4) @(negedge clk_50);
   endtask

   // done held low while a second command is pulsed and must be dropped
   task automatic hold_resp(input logic [RESP_W-1:0] held);
      phy_cmd_in = {2'b01, CMD13_SEND_STATUS, RCA_ARG, 7'h00, 1'b1};
      for (int i = 0; i < 30; i++) begin
         @(negedge clk_50);
         phy_cmd_in_act = (i >= 2 && i < 8);
         checks++;
         if (!phy_resp_act) begin
            $display("[ERROR] phy_resp_act: got %h, expected %h", phy_resp_act, 1'b1);
            errors++;
         end
         if (phy_resp_out !== held) begin
            $display("[ERROR] phy_resp_out: got %h, expected %h", phy_resp_out, held);
            errors++;
         end
      end
   endtask

   task automatic apply_row(input int row, input vec_t v);
      logic seen;
      send_cmd(v.idx, v.arg, v.crc);
      if (v.typ == RESP_NONE) begin
         expect_quiet(row);
      end else begin
         wait_resp(seen);
         checks++;
         if (!seen) begin
            $display("row %0d: no response within 40 cycles", row);
            errors++;
         end else begin
            if (phy_resp_type !== v.typ) begin
               $display("[ERROR] row %0d phy_resp_type: got %h, expected %h", row,
                        phy_resp_type, v.typ);
               errors++;
            end
            if (phy_resp_out !== v.tok) begin
               $display("[ERROR] row %0d phy_resp_out: got %h, expected %h", row,
                        phy_resp_out, v.tok);
               errors++;
            end
            if (v.hold) hold_resp(v.tok);
            release_resp(row);
            if (v.hold) expect_quiet(row);
         end
      end
      checks++;
      if (link_card_state !== v.st) begin
         $display("[ERROR] row %0d link_card_state: got %h, expected %h", row,
                  link_card_state, v.st);
         errors++;
      end
      if ({info_card_desel, err_unhandled_cmd, err_cmd_crc} !== v.flags) begin
         $display("[ERROR] row %0d desel/unhandled/crc flags: got %h, expected %h", row,
                  {info_card_desel, err_unhandled_cmd, err_cmd_crc}, v.flags);
         errors++;
      end
   endtask

   task automatic random_if_cond();
      vec_t        v;
      logic [31:0] arg;
      for (int i = 0; i < RAND_COUNT; i++) begin
         arg       = $urandom;
         arg[11:8] = 4'h1;
         v = {CMD8_SEND_IF_COND, arg, 1'b1, RESP_R7, echo_token(arg), CARD_IDLE, 3'b000, 1'b0};
         apply_row(100 + i, v);
      end
   endtask

   initial begin
      clk_50 = 1'b0;
      forever #2 clk_50 = ~clk_50;
   end

   initial begin
      wait (rows_loaded);
      repeat ((rows.size() + RAND_COUNT) * 200) @(posedge clk_50);
      $display("watchdog expired before the tests completed");
      $display("Test failed");
      $finish;
   end

   initial begin
      void'($urandom(90));
      reset_s             = 1'b0;
      phy_cmd_in          = '0;
      phy_cmd_in_crc_good = 1'b0;
      phy_cmd_in_act      = 1'b0;
      phy_resp_done       = 1'b0;
      load_rows();
      rows_loaded = 1'b1;
      repeat (8) @(negedge clk_50);
      reset_s = 1'b1;
      repeat (2) @(negedge clk_50);
      // random CMD8 rounds run once the first CMD0 has the card idle
      apply_row(0, rows[0]);
      random_if_cond();
      for (int r = 1; r < rows.size(); r++) begin
         apply_row(r, rows[r]);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+tests
logic/sd_pkg.sv
logic/edge_sync.sv
logic/cmd_decode.sv
logic/card_execute.sv
logic/resp_format.sv
logic/sd_cmd_link.sv
tests/tb_sd_cmd_link.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, then search the log for failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_sd_cmd_link \
   -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
